/* hdl/tcdm_bus_pkg.sv */
package tcdm_bus_pkg;

   //******************************
   // TCDM port geometry
   //******************************

   // Byte address into the TCDM
   localparam int unsigned TCDM_ADDR_W = 12;

   // One bus word
   localparam int unsigned TCDM_DATA_W = 32;

   // One enable bit per byte lane
   localparam int unsigned TCDM_BE_W   = TCDM_DATA_W / 8;

   // Address step from one beat to the next
   localparam int unsigned WORD_BYTES  = TCDM_DATA_W / 8;

   //******************************
   // Bus vector types
   //******************************

   // Low two bits stay zero for word aligned commands
   typedef logic [TCDM_ADDR_W-1:0] tcdm_addr_t;
   typedef logic [TCDM_DATA_W-1:0] tcdm_data_t;
   typedef logic [TCDM_BE_W-1:0]   tcdm_be_t;

endpackage

/* hdl/dma_cmd_pkg.sv */
package dma_cmd_pkg;

   // Transfer ID and burst length fields
   localparam int unsigned SID_W        = 2;
   localparam int unsigned LEN_W        = 8;

   // Storage depths
   localparam int unsigned CMD_DEPTH    = 2;
   localparam int unsigned TX_BUF_DEPTH = 2;

   typedef logic [SID_W-1:0] sid_t;

   // Number of words minus one
   typedef logic [LEN_W-1:0] beat_len_t;

   // Unpacker control
   typedef enum logic {
      IDLE,
      BURST
   } unpack_state_e;

   // Last requester shown on the shared port
   typedef enum logic {
      TX,
      RX
   } arb_grant_e;

endpackage

/* hdl/tcdm_cmd_unpack.sv */
module tcdm_cmd_unpack
   import tcdm_bus_pkg::*;
   import dma_cmd_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,

   input  logic       cmd_valid_i,
   output logic       cmd_ready_o,
   input  tcdm_addr_t cmd_addr_i,
   input  beat_len_t  cmd_len_i,
   input  sid_t       cmd_sid_i,

   output logic       beat_valid_o,
   input  logic       beat_ready_i,
   output tcdm_addr_t beat_addr_o,
   output logic       beat_eop_o,
   output sid_t       beat_sid_o
);

   tcdm_addr_t                       q_addr [CMD_DEPTH];
   beat_len_t                        q_len  [CMD_DEPTH];
   sid_t                             q_sid  [CMD_DEPTH];
   logic [$clog2(CMD_DEPTH)-1:0]     wr_ptr_q;
   logic [$clog2(CMD_DEPTH)-1:0]     rd_ptr_q;
   logic [$clog2(CMD_DEPTH+1)-1:0]   count_q;
   logic                             push;
   logic                             pop;

   unpack_state_e                    state_q;
   tcdm_addr_t                       addr_q;
   beat_len_t                        remain_q;

   //******************************
   // Command queue
   //******************************

   assign cmd_ready_o = 32'(count_q) < CMD_DEPTH;
   assign push        = cmd_valid_i && cmd_ready_o;

   // Head leaves the queue with its last beat
   assign pop         = beat_valid_o && beat_ready_i && beat_eop_o;

   always_ff @(posedge clk_i) begin
      if (push) begin
         q_addr[wr_ptr_q] <= cmd_addr_i;
         q_len[wr_ptr_q]  <= cmd_len_i;
         q_sid[wr_ptr_q]  <= cmd_sid_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   //******************************
   // Beat generation
   //******************************

   assign beat_valid_o = (state_q == BURST);
   assign beat_addr_o  = addr_q;
   assign beat_eop_o   = (remain_q == '0);
   assign beat_sid_o   = q_sid[rd_ptr_q];

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q  <= IDLE;
         addr_q   <= '0;
         remain_q <= '0;
      end else begin
         case (state_q)
            IDLE: begin
               // Load the head command
               if (count_q != '0) begin
                  state_q  <= BURST;
                  addr_q   <= q_addr[rd_ptr_q];
                  remain_q <= q_len[rd_ptr_q];
               end
            end
            BURST: begin
               if (beat_ready_i) begin
                  addr_q   <= addr_q + tcdm_addr_t'(WORD_BYTES);
                  remain_q <= remain_q - 1'b1;
                  if (beat_eop_o) begin
                     state_q <= IDLE;
                  end
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

endmodule

/* hdl/tcdm_tx_if.sv */
module tcdm_tx_if
   import tcdm_bus_pkg::*;
   import dma_cmd_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,

   input  logic       beat_valid_i,
   output logic       beat_ready_o,
   input  tcdm_addr_t beat_addr_i,
   input  logic       beat_eop_i,
   input  sid_t       beat_sid_i,

   output logic       mem_req_o,
   output tcdm_addr_t mem_addr_o,
   input  logic       mem_gnt_i,
   input  logic       mem_rvalid_i,
   input  tcdm_data_t mem_rdata_i,

   output logic       tx_data_valid_o,
   output tcdm_data_t tx_data_o,
   input  logic       tx_data_ready_i,

   output logic       synch_valid_o,
   output sid_t       synch_sid_o
);

   tcdm_data_t                        buf_data [TX_BUF_DEPTH];
   logic                              buf_eop  [TX_BUF_DEPTH];
   sid_t                              buf_sid  [TX_BUF_DEPTH];
   logic [$clog2(TX_BUF_DEPTH)-1:0]   wr_ptr_q;
   logic [$clog2(TX_BUF_DEPTH)-1:0]   rd_ptr_q;
   logic [$clog2(TX_BUF_DEPTH+1)-1:0] count_q;
   logic                              inflight_q;
   logic                              pend_eop_q;
   sid_t                              pend_sid_q;
   logic                              room;
   logic                              read_fire;
   logic                              pop;

   // A read goes out only if its word has a free buffer slot
   assign room         = (32'(count_q) + 32'(inflight_q)) < TX_BUF_DEPTH;
   assign mem_req_o    = beat_valid_i && room;
   assign mem_addr_o   = beat_addr_i;
   assign beat_ready_o = room && mem_gnt_i;
   assign read_fire    = mem_req_o && mem_gnt_i;

   // Tag of the read whose word returns next cycle
   always_ff @(posedge clk_i) begin
      if (read_fire) begin
         pend_eop_q <= beat_eop_i;
         pend_sid_q <= beat_sid_i;
      end
      if (mem_rvalid_i) begin
         buf_data[wr_ptr_q] <= mem_rdata_i;
         buf_eop[wr_ptr_q]  <= pend_eop_q;
         buf_sid[wr_ptr_q]  <= pend_sid_q;
      end
   end

   //******************************
   // Read data buffer
   //******************************

   assign tx_data_valid_o = (count_q != '0);
   assign tx_data_o       = buf_data[rd_ptr_q];
   assign pop             = tx_data_valid_o && tx_data_ready_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         inflight_q    <= 1'b0;
         wr_ptr_q      <= '0;
         rd_ptr_q      <= '0;
         count_q       <= '0;
         synch_valid_o <= 1'b0;
         synch_sid_o   <= '0;
      end else begin
         inflight_q <= read_fire;
         if (mem_rvalid_i) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({mem_rvalid_i, pop})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
         // Burst done once its last word leaves
         synch_valid_o <= pop && buf_eop[rd_ptr_q];
         if (pop && buf_eop[rd_ptr_q]) begin
            synch_sid_o <= buf_sid[rd_ptr_q];
         end
      end
   end

endmodule

/* hdl/tcdm_rx_if.sv */
module tcdm_rx_if
   import tcdm_bus_pkg::*;
   import dma_cmd_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,

   input  logic       beat_valid_i,
   output logic       beat_ready_o,
   input  tcdm_addr_t beat_addr_i,
   input  logic       beat_eop_i,
   input  sid_t       beat_sid_i,

   output logic       mem_req_o,
   output tcdm_addr_t mem_addr_o,
   output tcdm_data_t mem_wdata_o,
   output tcdm_be_t   mem_be_o,
   input  logic       mem_gnt_i,

   input  logic       rx_data_valid_i,
   input  tcdm_data_t rx_data_i,
   input  tcdm_be_t   rx_data_strb_i,
   output logic       rx_data_ready_o,

   output logic       synch_valid_o,
   output sid_t       synch_sid_o
);

   logic write_fire;

   // Write needs an address beat and a data word together
   assign mem_req_o   = beat_valid_i && rx_data_valid_i;
   assign mem_addr_o  = beat_addr_i;
   assign mem_wdata_o = rx_data_i;
   assign mem_be_o    = rx_data_strb_i;

   // Beat and word are consumed in the grant cycle
   assign beat_ready_o    = rx_data_valid_i && mem_gnt_i;
   assign rx_data_ready_o = beat_valid_i && mem_gnt_i;
   assign write_fire      = mem_req_o && mem_gnt_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         synch_valid_o <= 1'b0;
         synch_sid_o   <= '0;
      end else begin
         synch_valid_o <= write_fire && beat_eop_i;
         if (write_fire && beat_eop_i) begin
            synch_sid_o <= beat_sid_i;
         end
      end
   end

endmodule

/* hdl/tcdm_port_arb.sv */
module tcdm_port_arb
   import tcdm_bus_pkg::*;
   import dma_cmd_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,

   // Read requester
   input  logic       tx_req_i,
   input  tcdm_addr_t tx_addr_i,
   output logic       tx_gnt_o,
   output logic       tx_rvalid_o,
   output tcdm_data_t tx_rdata_o,

   // Write requester
   input  logic       rx_req_i,
   input  tcdm_addr_t rx_addr_i,
   input  tcdm_data_t rx_wdata_i,
   input  tcdm_be_t   rx_be_i,
   output logic       rx_gnt_o,

   // Shared TCDM port
   output logic       tcdm_req_o,
   output tcdm_addr_t tcdm_addr_o,
   output logic       tcdm_we_o,
   output tcdm_data_t tcdm_wdata_o,
   output tcdm_be_t   tcdm_be_o,
   input  logic       tcdm_gnt_i,
   input  logic       tcdm_r_valid_i,
   input  tcdm_data_t tcdm_r_rdata_i
);

   arb_grant_e last_q;
   arb_grant_e sel;
   logic       lock_q;

   // Stalled request keeps the port, otherwise alternate on contention
   always_comb begin
      if (lock_q) begin
         sel = last_q;
      end else if (tx_req_i && rx_req_i) begin
         sel = (last_q == TX) ? RX : TX;
      end else if (tx_req_i) begin
         sel = TX;
      end else begin
         sel = RX;
      end
   end

   assign tcdm_req_o   = (sel == TX) ? tx_req_i : rx_req_i;
   assign tcdm_addr_o  = (sel == TX) ? tx_addr_i : rx_addr_i;
   assign tcdm_we_o    = (sel == RX);
   assign tcdm_wdata_o = (sel == RX) ? rx_wdata_i : '0;
   assign tcdm_be_o    = (sel == RX) ? rx_be_i : '1;

   assign tx_gnt_o = (sel == TX) && tx_req_i && tcdm_gnt_i;
   assign rx_gnt_o = (sel == RX) && rx_req_i && tcdm_gnt_i;

   // Only reads return data
   assign tx_rvalid_o = tcdm_r_valid_i;
   assign tx_rdata_o  = tcdm_r_rdata_i;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         last_q <= RX;
         lock_q <= 1'b0;
      end else begin
         if (tcdm_req_o) begin
            last_q <= sel;
         end
         lock_q <= tcdm_req_o && !tcdm_gnt_i;
      end
   end

endmodule

/* hdl/tcdm_unit.sv */
module tcdm_unit
   import tcdm_bus_pkg::*;
   import dma_cmd_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_n_i,

   //******************************
   // Command inputs
   //******************************
   input  logic       tx_cmd_valid_i,
   output logic       tx_cmd_ready_o,
   input  tcdm_addr_t tx_cmd_addr_i,
   input  beat_len_t  tx_cmd_len_i,
   input  sid_t       tx_cmd_sid_i,

   input  logic       rx_cmd_valid_i,
   output logic       rx_cmd_ready_o,
   input  tcdm_addr_t rx_cmd_addr_i,
   input  beat_len_t  rx_cmd_len_i,
   input  sid_t       rx_cmd_sid_i,

   //******************************
   // TCDM port
   //******************************
   output logic       tcdm_req_o,
   output tcdm_addr_t tcdm_addr_o,
   output logic       tcdm_we_o,
   output tcdm_data_t tcdm_wdata_o,
   output tcdm_be_t   tcdm_be_o,
   input  logic       tcdm_gnt_i,
   input  logic       tcdm_r_valid_i,
   input  tcdm_data_t tcdm_r_rdata_i,

   //******************************
   // Data streams and synch
   //******************************
   output logic       tx_data_valid_o,
   output tcdm_data_t tx_data_o,
   input  logic       tx_data_ready_i,

   input  logic       rx_data_valid_i,
   input  tcdm_data_t rx_data_i,
   input  tcdm_be_t   rx_data_strb_i,
   output logic       rx_data_ready_o,

   output logic       tx_synch_valid_o,
   output sid_t       tx_synch_sid_o,
   output logic       rx_synch_valid_o,
   output sid_t       rx_synch_sid_o
);

   logic       tx_beat_valid;
   logic       tx_beat_ready;
   tcdm_addr_t tx_beat_addr;
   logic       tx_beat_eop;
   sid_t       tx_beat_sid;
   logic       rx_beat_valid;
   logic       rx_beat_ready;
   tcdm_addr_t rx_beat_addr;
   logic       rx_beat_eop;
   sid_t       rx_beat_sid;

   logic       tx_mem_req;
   tcdm_addr_t tx_mem_addr;
   logic       tx_mem_gnt;
   logic       tx_mem_rvalid;
   tcdm_data_t tx_mem_rdata;
   logic       rx_mem_req;
   tcdm_addr_t rx_mem_addr;
   tcdm_data_t rx_mem_wdata;
   tcdm_be_t   rx_mem_be;
   logic       rx_mem_gnt;

   tcdm_cmd_unpack tx_unpack_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (tx_cmd_valid_i),
      .cmd_ready_o  (tx_cmd_ready_o),
      .cmd_addr_i   (tx_cmd_addr_i),
      .cmd_len_i    (tx_cmd_len_i),
      .cmd_sid_i    (tx_cmd_sid_i),
      .beat_valid_o (tx_beat_valid),
      .beat_ready_i (tx_beat_ready),
      .beat_addr_o  (tx_beat_addr),
      .beat_eop_o   (tx_beat_eop),
      .beat_sid_o   (tx_beat_sid)
   );

   tcdm_cmd_unpack rx_unpack_i (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (rx_cmd_valid_i),
      .cmd_ready_o  (rx_cmd_ready_o),
      .cmd_addr_i   (rx_cmd_addr_i),
      .cmd_len_i    (rx_cmd_len_i),
      .cmd_sid_i    (rx_cmd_sid_i),
      .beat_valid_o (rx_beat_valid),
      .beat_ready_i (rx_beat_ready),
      .beat_addr_o  (rx_beat_addr),
      .beat_eop_o   (rx_beat_eop),
      .beat_sid_o   (rx_beat_sid)
   );

   tcdm_tx_if tx_if_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .beat_valid_i    (tx_beat_valid),
      .beat_ready_o    (tx_beat_ready),
      .beat_addr_i     (tx_beat_addr),
      .beat_eop_i      (tx_beat_eop),
      .beat_sid_i      (tx_beat_sid),
      .mem_req_o       (tx_mem_req),
      .mem_addr_o      (tx_mem_addr),
      .mem_gnt_i       (tx_mem_gnt),
      .mem_rvalid_i    (tx_mem_rvalid),
      .mem_rdata_i     (tx_mem_rdata),
      .tx_data_valid_o (tx_data_valid_o),
      .tx_data_o       (tx_data_o),
      .tx_data_ready_i (tx_data_ready_i),
      .synch_valid_o   (tx_synch_valid_o),
      .synch_sid_o     (tx_synch_sid_o)
   );

   tcdm_rx_if rx_if_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .beat_valid_i    (rx_beat_valid),
      .beat_ready_o    (rx_beat_ready),
      .beat_addr_i     (rx_beat_addr),
      .beat_eop_i      (rx_beat_eop),
      .beat_sid_i      (rx_beat_sid),
      .mem_req_o       (rx_mem_req),
      .mem_addr_o      (rx_mem_addr),
      .mem_wdata_o     (rx_mem_wdata),
      .mem_be_o        (rx_mem_be),
      .mem_gnt_i       (rx_mem_gnt),
      .rx_data_valid_i (rx_data_valid_i),
      .rx_data_i       (rx_data_i),
      .rx_data_strb_i  (rx_data_strb_i),
      .rx_data_ready_o (rx_data_ready_o),
      .synch_valid_o   (rx_synch_valid_o),
      .synch_sid_o     (rx_synch_sid_o)
   );

   tcdm_port_arb port_arb_i (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .tx_req_i       (tx_mem_req),
      .tx_addr_i      (tx_mem_addr),
      .tx_gnt_o       (tx_mem_gnt),
      .tx_rvalid_o    (tx_mem_rvalid),
      .tx_rdata_o     (tx_mem_rdata),
      .rx_req_i       (rx_mem_req),
      .rx_addr_i      (rx_mem_addr),
      .rx_wdata_i     (rx_mem_wdata),
      .rx_be_i        (rx_mem_be),
      .rx_gnt_o       (rx_mem_gnt),
      .tcdm_req_o     (tcdm_req_o),
      .tcdm_addr_o    (tcdm_addr_o),
      .tcdm_we_o      (tcdm_we_o),
      .tcdm_wdata_o   (tcdm_wdata_o),
      .tcdm_be_o      (tcdm_be_o),
      .tcdm_gnt_i     (tcdm_gnt_i),
      .tcdm_r_valid_i (tcdm_r_valid_i),
      .tcdm_r_rdata_i (tcdm_r_rdata_i)
   );

endmodule

/* verification/tcdm_unit_assert.sv */
module tcdm_unit_assert
   import tcdm_bus_pkg::*;
(
   input logic       clk_i,
   input logic       rst_n_i,
   input logic       tcdm_req_o,
   input tcdm_addr_t tcdm_addr_o,
   input logic       tcdm_we_o,
   input tcdm_data_t tcdm_wdata_o,
   input tcdm_be_t   tcdm_be_o,
   input logic       tcdm_gnt_i,
   input logic       tcdm_r_valid_i,
   input logic       tx_data_valid_o,
   input tcdm_data_t tx_data_o,
   input logic       tx_data_ready_i
);

   // Stalled TCDM request keeps all of its fields
   req_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tcdm_req_o && !tcdm_gnt_i |=> tcdm_req_o && $stable(tcdm_addr_o) &&
      $stable(tcdm_we_o) && $stable(tcdm_wdata_o) && $stable(tcdm_be_o))
      else $error("TCDM request or its fields changed before grant");

   // Stream word waits for ready
   tx_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tx_data_valid_o && !tx_data_ready_i |=> tx_data_valid_o && $stable(tx_data_o))
      else $error("tx_data valid or data changed before ready");

   rvalid_cause: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      tcdm_r_valid_i |-> $past(tcdm_req_o && tcdm_gnt_i && !tcdm_we_o))
      else $error("read data returned without a granted read");

   req_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !tcdm_req_o)
      else $error("TCDM request high in the first cycle after reset");

endmodule

/* verification/tcdm_unit_tb.sv */
module tcdm_unit_tb
   import tcdm_bus_pkg::*;
   import dma_cmd_pkg::*;
();

   localparam int MEM_WORDS   = 1024;
   // Beats over all tests, read-back included
   localparam int TOTAL_BEATS = 65;
   localparam int CYCLE_LIMIT = 20 * TOTAL_BEATS + 200;

   logic       clk_i           = 1'b0;
   logic       rst_n_i         = 1'b0;
   logic       tx_cmd_valid_i  = 1'b0;
   tcdm_addr_t tx_cmd_addr_i   = '0;
   beat_len_t  tx_cmd_len_i    = '0;
   sid_t       tx_cmd_sid_i    = '0;
   logic       rx_cmd_valid_i  = 1'b0;
   tcdm_addr_t rx_cmd_addr_i   = '0;
   beat_len_t  rx_cmd_len_i    = '0;
   sid_t       rx_cmd_sid_i    = '0;
   logic       tcdm_gnt_i      = 1'b0;
   logic       tcdm_r_valid_i  = 1'b0;
   tcdm_data_t tcdm_r_rdata_i  = '0;
   logic       tx_data_ready_i = 1'b0;
   logic       rx_data_valid_i = 1'b0;
   tcdm_data_t rx_data_i       = '0;
   tcdm_be_t   rx_data_strb_i  = '0;

   logic       tx_cmd_ready_o;
   logic       rx_cmd_ready_o;
   logic       tcdm_req_o;
   tcdm_addr_t tcdm_addr_o;
   logic       tcdm_we_o;
   tcdm_data_t tcdm_wdata_o;
   tcdm_be_t   tcdm_be_o;
   logic       tx_data_valid_o;
   tcdm_data_t tx_data_o;
   logic       rx_data_ready_o;
   logic       tx_synch_valid_o;
   sid_t       tx_synch_sid_o;
   logic       rx_synch_valid_o;
   sid_t       rx_synch_sid_o;

   logic [31:0] lfsr_q = 32'h2f1486c8;
   int          cycle_cnt = 0;
   tcdm_data_t  mem     [MEM_WORDS];
   tcdm_data_t  ref_mem [MEM_WORDS];

   // Last word of a burst taken or last write granted in the previous cycle
   logic        tx_last_taken   = 1'b0;
   logic        rx_last_granted = 1'b0;

   // Expected traffic, in order
   tcdm_data_t  tx_word_q[$];
   logic        tx_last_q[$];
   sid_t        tx_sid_q[$];
   sid_t        rx_sid_q[$];
   tcdm_addr_t  rd_addr_q[$];
   tcdm_addr_t  wr_addr_q[$];
   logic        wr_last_q[$];
   tcdm_addr_t  rx_pend_addr_q[$];

   tcdm_unit uut (.*);

   bind tcdm_unit tcdm_unit_assert assert_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .tcdm_req_o      (tcdm_req_o),
      .tcdm_addr_o     (tcdm_addr_o),
      .tcdm_we_o       (tcdm_we_o),
      .tcdm_wdata_o    (tcdm_wdata_o),
      .tcdm_be_o       (tcdm_be_o),
      .tcdm_gnt_i      (tcdm_gnt_i),
      .tcdm_r_valid_i  (tcdm_r_valid_i),
      .tx_data_valid_o (tx_data_valid_o),
      .tx_data_o       (tx_data_o),
      .tx_data_ready_i (tx_data_ready_i)
   );

   initial begin
      forever #50 clk_i = ~clk_i;
   end

   //******************************
   // Helpers and compare tasks
   //******************************

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] val;
      logic        fb;
      int          k;
      val = '0;
      for (k = 0; k < n; k++) begin
         fb    = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         val   = {val[30:0], fb};
      end
      return val;
   endfunction

   function automatic tcdm_data_t fill_word(input int unsigned i);
      return tcdm_data_t'(i * 32'h9e3779b1) ^ 32'h6b43a9c5;
   endfunction

   task automatic abort_run();
      $display("test failed");
      $fatal(1);
   endtask

   task automatic fail_with_message(input string msg);
      $display("%s", msg);
      abort_run();
   endtask

   task automatic compare_data(input string name, input tcdm_data_t got, input tcdm_data_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_sid(input string name, input sid_t got, input sid_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_addr(input string name, input tcdm_addr_t got, input tcdm_addr_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_be(input string name, input tcdm_be_t got, input tcdm_be_t exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("** Error: %s = %h, expected %h", name, got, exp);
         abort_run();
      end
   endtask

   //******************************
   // TCDM model and stream drivers
   //******************************

   always @(posedge clk_i) begin
      logic [9:0] idx;
      tcdm_addr_t a;
      tcdm_data_t word;
      tcdm_be_t   strb;
      if (!rst_n_i) begin
         for (int unsigned i = 0; i < MEM_WORDS; i++) begin
            mem[i]     <= fill_word(i);
            ref_mem[i] = fill_word(i);
         end
      end else begin
         idx = tcdm_addr_o[TCDM_ADDR_W-1:2];
         tcdm_r_valid_i  <= tcdm_req_o && tcdm_gnt_i && !tcdm_we_o;
         rx_last_granted <= 1'b0;
         if (tcdm_req_o && tcdm_gnt_i && tcdm_we_o) begin
            if (wr_addr_q.size() == 0) begin
               fail_with_message("TCDM write granted with no receive beat outstanding");
            end
            compare_addr("tcdm_addr_o", tcdm_addr_o, wr_addr_q.pop_front());
            rx_last_granted <= wr_last_q.pop_front();
            for (int b = 0; b < TCDM_BE_W; b++) begin
               if (tcdm_be_o[b]) begin
                  mem[idx][8*b +: 8] <= tcdm_wdata_o[8*b +: 8];
               end
            end
         end else if (tcdm_req_o && tcdm_gnt_i) begin
            if (rd_addr_q.size() == 0) begin
               fail_with_message("TCDM read granted with no transmit beat outstanding");
            end
            compare_addr("tcdm_addr_o", tcdm_addr_o, rd_addr_q.pop_front());
            // Reads enable every byte lane
            compare_be("tcdm_be_o", tcdm_be_o, '1);
            tcdm_r_rdata_i <= mem[idx];
         end
         // About three grants in four, ready half the time
         tcdm_gnt_i      <= (rand_bits(2) != 0);
         tx_data_ready_i <= (rand_bits(1) != 0);
         // Next receive word once the shown one is taken
         if (!rx_data_valid_i || rx_data_ready_o) begin
            if (rx_pend_addr_q.size() != 0 && rand_bits(1) != 0) begin
               a    = rx_pend_addr_q.pop_front();
               word = rand_bits(32);
               strb = tcdm_be_t'(rand_bits(TCDM_BE_W));
               for (int b = 0; b < TCDM_BE_W; b++) begin
                  if (strb[b]) begin
                     ref_mem[a[TCDM_ADDR_W-1:2]][8*b +: 8] = word[8*b +: 8];
                  end
               end
               rx_data_valid_i <= 1'b1;
               rx_data_i       <= word;
               rx_data_strb_i  <= strb;
            end else begin
               rx_data_valid_i <= 1'b0;
            end
         end
      end
   end

   // Stream and synch monitor
   always @(posedge clk_i) begin
      if (rst_n_i) begin
         // Synch pulses exactly one cycle after the burst's last word or write
         compare_flag("tx_synch_valid_o", tx_synch_valid_o, tx_last_taken);
         compare_flag("rx_synch_valid_o", rx_synch_valid_o, rx_last_granted);
         tx_last_taken <= 1'b0;
         if (tx_data_valid_o && tx_data_ready_i) begin
            if (tx_word_q.size() == 0) begin
               fail_with_message("tx_data carried a word that no command asked for");
            end
            compare_data("tx_data_o", tx_data_o, tx_word_q.pop_front());
            tx_last_taken <= tx_last_q.pop_front();
         end
         if (tx_synch_valid_o) begin
            if (tx_sid_q.size() == 0) begin
               fail_with_message("tx synch pulse with no transmit command open");
            end
            compare_sid("tx_synch_sid_o", tx_synch_sid_o, tx_sid_q.pop_front());
         end
         if (rx_synch_valid_o) begin
            if (rx_sid_q.size() == 0) begin
               fail_with_message("rx synch pulse with no receive command open");
            end
            compare_sid("rx_synch_sid_o", rx_synch_sid_o, rx_sid_q.pop_front());
         end
      end
   end

   always @(posedge clk_i) begin
      cycle_cnt++;
      if (cycle_cnt == CYCLE_LIMIT) begin
         fail_with_message("Timeout: the tests did not finish within the cycle limit");
      end
   end

   //******************************
   // Command tasks and tests
   //******************************

   task automatic send_tx_cmd(input tcdm_addr_t addr, input beat_len_t len, input sid_t sid);
      tcdm_addr_t a;
      int         k;
      a = addr;
      for (k = 0; k <= int'(len); k++) begin
         rd_addr_q.push_back(a);
         tx_word_q.push_back(ref_mem[a[TCDM_ADDR_W-1:2]]);
         tx_last_q.push_back(k == int'(len));
         a = a + tcdm_addr_t'(WORD_BYTES);
      end
      tx_sid_q.push_back(sid);
      tx_cmd_valid_i <= 1'b1;
      tx_cmd_addr_i  <= addr;
      tx_cmd_len_i   <= len;
      tx_cmd_sid_i   <= sid;
      @(posedge clk_i);
      while (!tx_cmd_ready_o) @(posedge clk_i);
      tx_cmd_valid_i <= 1'b0;
   endtask

   task automatic send_rx_cmd(input tcdm_addr_t addr, input beat_len_t len, input sid_t sid);
      tcdm_addr_t a;
      int         k;
      a = addr;
      for (k = 0; k <= int'(len); k++) begin
         wr_addr_q.push_back(a);
         wr_last_q.push_back(k == int'(len));
         rx_pend_addr_q.push_back(a);
         a = a + tcdm_addr_t'(WORD_BYTES);
      end
      rx_sid_q.push_back(sid);
      rx_cmd_valid_i <= 1'b1;
      rx_cmd_addr_i  <= addr;
      rx_cmd_len_i   <= len;
      rx_cmd_sid_i   <= sid;
      @(posedge clk_i);
      while (!rx_cmd_ready_o) @(posedge clk_i);
      rx_cmd_valid_i <= 1'b0;
   endtask

   // Every open burst has sent its synch pulse
   task automatic wait_idle();
      while (tx_sid_q.size() != 0 || rx_sid_q.size() != 0) @(posedge clk_i);
   endtask

   task automatic check_reset_state();
      @(posedge clk_i);
      compare_flag("tcdm_req_o", tcdm_req_o, 1'b0);
      compare_flag("tx_data_valid_o", tx_data_valid_o, 1'b0);
      compare_flag("tx_synch_valid_o", tx_synch_valid_o, 1'b0);
      compare_flag("rx_synch_valid_o", rx_synch_valid_o, 1'b0);
      compare_flag("tx_cmd_ready_o", tx_cmd_ready_o, 1'b1);
      compare_flag("rx_cmd_ready_o", rx_cmd_ready_o, 1'b1);
   endtask

   task automatic tx_burst_readout();
      send_tx_cmd(12'h010, 8'd0, 2'd1);
      wait_idle();
      send_tx_cmd(12'h100, 8'd6, 2'd2);
      wait_idle();
   endtask

   task automatic rx_strobe_write();
      send_rx_cmd(12'h200, 8'd5, 2'd3);
      wait_idle();
      send_tx_cmd(12'h200, 8'd5, 2'd0);
      wait_idle();
   endtask

   task automatic dual_path_traffic();
      send_tx_cmd(12'h300, 8'd7, 2'd1);
      send_rx_cmd(12'h400, 8'd7, 2'd2);
      wait_idle();
      send_tx_cmd(12'h400, 8'd7, 2'd3);
      wait_idle();
   endtask

   // Head command stays queued until its last beat, so both entries are taken
   task automatic back_to_back_cmds();
      send_tx_cmd(12'h080, 8'd3, 2'd2);
      send_tx_cmd(12'h0c0, 8'd2, 2'd3);
      @(posedge clk_i);
      compare_flag("tx_cmd_ready_o", tx_cmd_ready_o, 1'b0);
      send_rx_cmd(12'h500, 8'd4, 2'd0);
      send_rx_cmd(12'h540, 8'd1, 2'd1);
      @(posedge clk_i);
      compare_flag("rx_cmd_ready_o", rx_cmd_ready_o, 1'b0);
      wait_idle();
      send_tx_cmd(12'h500, 8'd4, 2'd1);
      send_tx_cmd(12'h540, 8'd1, 2'd2);
      wait_idle();
   endtask

   initial begin
      repeat (2) @(posedge clk_i);
      rst_n_i <= 1'b1;
      check_reset_state();
      tx_burst_readout();
      rx_strobe_write();
      dual_path_traffic();
      back_to_back_cmds();
      if (tx_word_q.size() == 0 && rd_addr_q.size() == 0 && wr_addr_q.size() == 0 &&
          rx_pend_addr_q.size() == 0) begin
         $display("test passed");
         $finish;
      end else begin
         fail_with_message("Expected TCDM accesses or stream words were never seen");
      end
   end

endmodule

/* build.f */
hdl/tcdm_bus_pkg.sv
hdl/dma_cmd_pkg.sv
hdl/tcdm_cmd_unpack.sv
hdl/tcdm_tx_if.sv
hdl/tcdm_rx_if.sv
hdl/tcdm_port_arb.sv
hdl/tcdm_unit.sv
verification/tcdm_unit_assert.sv
verification/tcdm_unit_tb.sv

/* Makefile */
# Verilator build of the TCDM unit testbench

VERILATOR ?= verilator
TOP       ?= tcdm_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
